// File: all.f
rtl/mempool_pkg.sv
rtl/mempool_addr_map_pkg.sv
rtl/l2_bank.sv
rtl/l2_mem.sv
rtl/bootrom.sv
rtl/ctrl_registers.sv
rtl/soc_xbar.sv
rtl/mempool_system.sv
tests/tb_mempool_system.sv

// File: Makefile
TOP = tb_mempool_system

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// File: tests/tb_mempool_system.sv
// Testbench for the MemPool memory system
// Drives the host port and checks every response against a reference model

module tb_mempool_system
  import mempool_pkg::*;
  import mempool_addr_map_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumCores    = 4;
  localparam int unsigned L2Words     = 4 * 256;
  localparam int unsigned FillWords   = 32;
  localparam int unsigned NumDirected = 32;
  localparam int unsigned NumRandom   = 300;
  localparam int unsigned ClkPeriod   = 4;
  localparam int unsigned TimeoutNs   =
    (2 * FillWords + NumDirected + NumRandom) * ClkPeriod + 200;
  localparam addr_t RomWindow    = 32'h0001_0000;
  localparam addr_t UnmappedAddr = 32'h1000_0000;

  logic                clk_i;
  logic                rst_n_i;
  logic                req_i;
  logic                we_i;
  addr_t               addr_i;
  data_t               wdata_i;
  strb_t               strb_i;
  logic                rvalid_o;
  logic                err_o;
  data_t               rdata_o;
  logic [NumCores-1:0] wake_up_o;
  logic                eoc_valid_o;

  // Expected response, driven together with its request
  logic                exp_err;
  logic                exp_chk;
  data_t               exp_rdata;
  logic [NumCores-1:0] exp_wake;
  logic                exp_eoc;

  // Expected response, due in the current cycle
  logic                pend_valid;
  logic                pend_err;
  logic                pend_chk;
  data_t               pend_rdata;
  logic [NumCores-1:0] pend_wake;
  logic                pend_eoc;

  // Reference model state
  data_t l2_model [int unsigned];
  data_t eoc_reg;
  data_t scratch_reg;
  int    seed;

  mempool_system mempool_system_inst (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (req_i      ),
    .we_i       (we_i       ),
    .addr_i     (addr_i     ),
    .wdata_i    (wdata_i    ),
    .strb_i     (strb_i     ),
    .rvalid_o   (rvalid_o   ),
    .err_o      (err_o      ),
    .rdata_o    (rdata_o    ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic report_value(input string name, input data_t expected, input data_t actual);
    $display("** Error at %0d ns: %s expected 0x%h, actual 0x%h", $time, name, expected, actual);
    $display("Done: errors found");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  // Compute the expected response from the address map, then issue the request
  task automatic send(input logic we, input addr_t addr, input data_t wdata, input strb_t strb);
    logic                err;
    logic                chk;
    data_t               rdata;
    logic [NumCores-1:0] wake;
    addr_t               off;
    int unsigned         idx;
    err   = 1'b0;
    chk   = 1'b1;
    rdata = '0;
    wake  = '0;
    if (addr >= L2MemoryBaseAddr && addr < L2MemoryBaseAddr + addr_t'(L2Words * 4)) begin
      idx = (addr - L2MemoryBaseAddr) >> 2;
      if (we) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (strb[b]) begin
            l2_model[idx][b*8 +: 8] = wdata[b*8 +: 8];
          end
        end
      end else if (l2_model.exists(idx)) begin
        rdata = l2_model[idx];
      end else begin
        chk = 1'b0;
      end
    end else if (addr >= BootromBaseAddr && addr < BootromBaseAddr + RomWindow) begin
      idx = (addr - BootromBaseAddr) >> 2;
      if (we) begin
        err = 1'b1;
      end else begin
        rdata = {BootromTag, 16'(idx % BootromNumWords)};
      end
    end else if (addr >= CtrlBaseAddr && addr < CtrlBaseAddr + CtrlSize) begin
      off = addr - CtrlBaseAddr;
      if (we) begin
        if (off == EocOffset) eoc_reg = wdata;
        if (off == ScratchOffset) scratch_reg = wdata;
        if (off == WakeUpOffset) wake = wdata[NumCores-1:0];
      end else begin
        if (off == EocOffset) rdata = eoc_reg;
        if (off == NumCoresOffset) rdata = data_t'(NumCores);
        if (off == ScratchOffset) rdata = scratch_reg;
      end
    end else begin
      err = 1'b1;
    end
    @(posedge clk_i);
    req_i     <= 1'b1;
    we_i      <= we;
    addr_i    <= addr;
    wdata_i   <= wdata;
    strb_i    <= strb;
    exp_err   <= err;
    exp_chk   <= chk;
    exp_rdata <= rdata;
    exp_wake  <= wake;
    exp_eoc   <= eoc_reg[0];
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      req_i <= 1'b0;
      we_i  <= 1'b0;
    end
  endtask

  task automatic random_request();
    int unsigned sel;
    int unsigned idx;
    sel = $unsigned($random(seed)) % 8;
    idx = $unsigned($random(seed));
    case (sel)
      0: send(1'b0, L2MemoryBaseAddr + addr_t'((idx % FillWords) * 4), '0, '0);
      1: send(1'b0, L2MemoryBaseAddr + addr_t'((idx % L2Words) * 4), '0, '0);
      2, 3: send(1'b1, L2MemoryBaseAddr + addr_t'((idx % FillWords) * 4), $random(seed),
                 strb_t'($random(seed)));
      4: send(1'b1, L2MemoryBaseAddr + addr_t'((idx % L2Words) * 4), $random(seed), '1);
      5: send(1'b0, BootromBaseAddr + addr_t'((idx % 256) * 4), '0, '0);
      6: send(idx[16], CtrlBaseAddr + addr_t'((idx % 5) * 4), $random(seed), '1);
      default: send(idx[16], UnmappedAddr + addr_t'((idx % 64) * 4), $random(seed), '1);
    endcase
  endtask

  // Delay the expectation by one cycle so it lines up with the response
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_valid <= 1'b0;
      pend_err   <= 1'b0;
      pend_chk   <= 1'b0;
      pend_rdata <= '0;
      pend_wake  <= '0;
      pend_eoc   <= 1'b0;
    end else begin
      pend_valid <= req_i;
      pend_err   <= req_i && exp_err;
      pend_chk   <= req_i && exp_chk;
      pend_rdata <= exp_rdata;
      pend_wake  <= req_i ? exp_wake : '0;
      if (req_i) begin
        pend_eoc <= exp_eoc;
      end
    end
  end

  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i) rvalid_o == pend_valid)
    else report_value("rvalid_o", data_t'($sampled(pend_valid)), data_t'($sampled(rvalid_o)));
  a_err: assert property (@(posedge clk_i) disable iff (!rst_n_i) err_o == pend_err)
    else report_value("err_o", data_t'($sampled(pend_err)), data_t'($sampled(err_o)));
  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                            !pend_chk || rdata_o == pend_rdata)
    else report_value("rdata_o", $sampled(pend_rdata), $sampled(rdata_o));
  a_wake: assert property (@(posedge clk_i) disable iff (!rst_n_i) wake_up_o == pend_wake)
    else report_value("wake_up_o", data_t'($sampled(pend_wake)), data_t'($sampled(wake_up_o)));
  a_eoc: assert property (@(posedge clk_i) disable iff (!rst_n_i) eoc_valid_o == pend_eoc)
    else report_value("eoc_valid_o", data_t'($sampled(pend_eoc)), data_t'($sampled(eoc_valid_o)));

  initial begin
    #(TimeoutNs);
    $display("Watchdog timeout, the test did not finish within %0d ns", TimeoutNs);
    $display("Done: errors found");
    $fatal(1, "Simulation timed out");
  end

  initial begin
    rst_n_i     = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    strb_i      = '0;
    exp_err     = 1'b0;
    exp_chk     = 1'b0;
    exp_rdata   = '0;
    exp_wake    = '0;
    exp_eoc     = 1'b0;
    eoc_reg     = '0;
    scratch_reg = '0;
    seed        = 54566;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    idle(2);

    // Consecutive L2 words across all banks, then read back
    for (int i = 0; i < FillWords; i++) begin
      send(1'b1, L2MemoryBaseAddr + addr_t'(i * 4), $random(seed), '1);
    end
    for (int i = 0; i < FillWords; i++) begin
      send(1'b0, L2MemoryBaseAddr + addr_t'(i * 4), '0, '0);
    end

    // Boot ROM pattern, index wrap and a rejected write
    send(1'b0, BootromBaseAddr, '0, '0);
    send(1'b0, BootromBaseAddr + 32'h14, '0, '0);
    send(1'b0, BootromBaseAddr + 32'h118, '0, '0);
    send(1'b1, BootromBaseAddr + 32'h14, 32'hDEAD_BEEF, '1);
    send(1'b0, BootromBaseAddr + 32'h14, '0, '0);

    send(1'b0, CtrlBaseAddr + NumCoresOffset, '0, '0);
    send(1'b1, CtrlBaseAddr + ScratchOffset, 32'h1234_5678, '1);
    send(1'b0, CtrlBaseAddr + ScratchOffset, '0, '0);
    send(1'b1, CtrlBaseAddr + EocOffset, 32'h1, '1);
    idle(2);
    send(1'b1, CtrlBaseAddr + EocOffset, 32'h0, '1);
    send(1'b0, CtrlBaseAddr + EocOffset, '0, '0);

    // Wake-up pulses, the slot itself reads as zero
    send(1'b1, CtrlBaseAddr + WakeUpOffset, 32'hFFFF_FFF5, '1);
    idle(3);
    send(1'b1, CtrlBaseAddr + WakeUpOffset, 32'h3, '1);
    send(1'b0, CtrlBaseAddr + WakeUpOffset, '0, '0);

    send(1'b0, UnmappedAddr, '0, '0);
    send(1'b1, UnmappedAddr, 32'hCAFE_F00D, '1);
    send(1'b0, 32'hC000_0000, '0, '0);

    // Random traffic on every cycle
    for (int n = 0; n < NumRandom; n++) begin
      random_request();
    end
    idle(3);
    $display("Done: no errors");
    $finish;
  end

endmodule : tb_mempool_system

// File: rtl/mempool_system.sv
// MemPool memory system top level
// Host strobe port decoded onto banked L2, boot ROM and control registers

module mempool_system
  import mempool_pkg::*;
  import mempool_addr_map_pkg::*;
#(
  parameter int unsigned NumCores       = 4,
  parameter int unsigned NumL2Banks     = 4,
  parameter int unsigned L2BankNumWords = 256,
  parameter addr_t       TCDMBaseAddr   = 32'h0000_0000
) (
  input  logic                clk_i,
  input  logic                rst_n_i,

  // Host request
  input  logic                req_i,
  input  logic                we_i,
  input  addr_t               addr_i,
  input  data_t               wdata_i,
  input  strb_t               strb_i,

  // Host response, one cycle after the request
  output logic                rvalid_o,
  output logic                err_o,
  output data_t               rdata_o,

  output logic [NumCores-1:0] wake_up_o,
  output logic                eoc_valid_o
);

  // L2 window size in bytes
  localparam addr_t L2Size = addr_t'(NumL2Banks * L2BankNumWords * StrbWidth);

  // The TCDM lives in the cluster and must stay clear of the L2 window
  if (TCDMBaseAddr >= L2MemoryBaseAddr && TCDMBaseAddr < L2MemoryBaseAddr + L2Size)
  begin : gen_tcdm_overlap
    $error("TCDM base address falls inside the L2 window");
  end

  logic  l2_req;
  logic  rom_req;
  logic  ctrl_req;
  logic  tgt_we;
  addr_t tgt_offset;
  data_t tgt_wdata;
  strb_t tgt_strb;
  data_t l2_rdata;
  data_t rom_rdata;
  data_t ctrl_rdata;

  soc_xbar #(
    .L2Size(L2Size)
  ) soc_xbar_inst (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .req_i       (req_i      ),
    .we_i        (we_i       ),
    .addr_i      (addr_i     ),
    .wdata_i     (wdata_i    ),
    .strb_i      (strb_i     ),
    .rvalid_o    (rvalid_o   ),
    .err_o       (err_o      ),
    .rdata_o     (rdata_o    ),
    .l2_req_o    (l2_req     ),
    .rom_req_o   (rom_req    ),
    .ctrl_req_o  (ctrl_req   ),
    .we_o        (tgt_we     ),
    .offset_o    (tgt_offset ),
    .wdata_o     (tgt_wdata  ),
    .strb_o      (tgt_strb   ),
    .l2_rdata_i  (l2_rdata   ),
    .rom_rdata_i (rom_rdata  ),
    .ctrl_rdata_i(ctrl_rdata )
  );

  l2_mem #(
    .NumL2Banks    (NumL2Banks    ),
    .L2BankNumWords(L2BankNumWords)
  ) l2_mem_inst (
    .clk_i   (clk_i     ),
    .req_i   (l2_req    ),
    .we_i    (tgt_we    ),
    .offset_i(tgt_offset),
    .wdata_i (tgt_wdata ),
    .strb_i  (tgt_strb  ),
    .rdata_o (l2_rdata  )
  );

  bootrom bootrom_inst (
    .clk_i   (clk_i     ),
    .req_i   (rom_req   ),
    .offset_i(tgt_offset),
    .rdata_o (rom_rdata )
  );

  ctrl_registers #(
    .NumCores(NumCores)
  ) ctrl_registers_inst (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (ctrl_req   ),
    .we_i       (tgt_we     ),
    .offset_i   (tgt_offset ),
    .wdata_i    (tgt_wdata  ),
    .rdata_o    (ctrl_rdata ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

endmodule : mempool_system

// File: rtl/soc_xbar.sv
// System address decoder
// Routes each host request to one target and returns the response a cycle later

module soc_xbar
  import mempool_pkg::*;
  import mempool_addr_map_pkg::*;
#(
  parameter addr_t L2Size = 32'h0000_1000
) (
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  strb_t strb_i,

  output logic  rvalid_o,
  output logic  err_o,
  output data_t rdata_o,

  // Target side
  output logic  l2_req_o,
  output logic  rom_req_o,
  output logic  ctrl_req_o,
  output logic  we_o,
  output addr_t offset_o,
  output data_t wdata_o,
  output strb_t strb_o,
  input  data_t l2_rdata_i,
  input  data_t rom_rdata_i,
  input  data_t ctrl_rdata_i
);

  // Boot ROM window is larger than the ROM, word index wraps inside
  localparam addr_t BootromSize    = 32'h0001_0000;
  localparam addr_t L2EndAddr      = L2MemoryBaseAddr + L2Size;
  localparam addr_t BootromEndAddr = BootromBaseAddr + BootromSize;
  localparam addr_t CtrlEndAddr    = CtrlBaseAddr + CtrlSize;

  target_e tgt;
  addr_t   offset;
  logic    err;
  target_e rsp_tgt_q;
  logic    rvalid_q;
  logic    err_q;

  // Window decode
  always_comb begin
    tgt    = TgtNone;
    offset = '0;
    if (addr_i >= L2MemoryBaseAddr && addr_i < L2EndAddr) begin
      tgt    = TgtL2;
      offset = addr_i - L2MemoryBaseAddr;
    end else if (addr_i >= BootromBaseAddr && addr_i < BootromEndAddr) begin
      tgt    = TgtBootrom;
      offset = addr_i - BootromBaseAddr;
    end else if (addr_i >= CtrlBaseAddr && addr_i < CtrlEndAddr) begin
      tgt    = TgtCtrl;
      offset = addr_i - CtrlBaseAddr;
    end
  end

  // Unmapped addresses and ROM writes are answered with an error
  assign err = (tgt == TgtNone) || (tgt == TgtBootrom && we_i);

  assign l2_req_o   = req_i && (tgt == TgtL2);
  assign rom_req_o  = req_i && (tgt == TgtBootrom) && !we_i;
  assign ctrl_req_o = req_i && (tgt == TgtCtrl);
  assign we_o       = we_i;
  assign offset_o   = offset;
  assign wdata_o    = wdata_i;
  assign strb_o     = strb_i;

  // Writes and errors select no read data, so they answer with zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q  <= 1'b0;
      err_q     <= 1'b0;
      rsp_tgt_q <= TgtNone;
    end else begin
      rvalid_q  <= req_i;
      err_q     <= req_i && err;
      rsp_tgt_q <= (req_i && !we_i) ? tgt : TgtNone;
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

  always_comb begin
    unique case (rsp_tgt_q)
      TgtL2:      rdata_o = l2_rdata_i;
      TgtBootrom: rdata_o = rom_rdata_i;
      TgtCtrl:    rdata_o = ctrl_rdata_i;
      default:    rdata_o = '0;
    endcase
  end

endmodule : soc_xbar

// File: rtl/ctrl_registers.sv
// Control and status registers
// End of computation, core wake-up, core count and a scratch word

module ctrl_registers
  import mempool_pkg::*;
  import mempool_addr_map_pkg::*;
#(
  parameter int unsigned NumCores = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  addr_t               offset_i,
  input  data_t               wdata_i,
  output data_t               rdata_o,
  output logic [NumCores-1:0] wake_up_o,
  output logic                eoc_valid_o
);

  data_t               eoc_q;
  data_t               scratch_q;
  logic [NumCores-1:0] wake_up_q;
  data_t               rdata_d;
  data_t               rdata_q;
  logic                wr_en;

  assign wr_en = req_i && we_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      eoc_q     <= '0;
      scratch_q <= '0;
      wake_up_q <= '0;
    end else begin
      if (wr_en && offset_i == EocOffset) begin
        eoc_q <= wdata_i;
      end
      if (wr_en && offset_i == ScratchOffset) begin
        scratch_q <= wdata_i;
      end
      // Wake-up is a single-cycle pulse, never held
      wake_up_q <= (wr_en && offset_i == WakeUpOffset) ? wdata_i[NumCores-1:0] : '0;
    end
  end

  // Read mux, unknown offsets and the wake-up slot read as zero
  always_comb begin
    unique case (offset_i)
      EocOffset:      rdata_d = eoc_q;
      NumCoresOffset: rdata_d = data_t'(NumCores);
      ScratchOffset:  rdata_d = scratch_q;
      default:        rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o     = rdata_q;
  assign wake_up_o   = wake_up_q;
  assign eoc_valid_o = eoc_q[0];

endmodule : ctrl_registers

// File: rtl/bootrom.sv
// Boot ROM
// Fixed word pattern with the ROM tag on top and the word index below

module bootrom
  import mempool_pkg::*;
  import mempool_addr_map_pkg::*;
(
  input  logic  clk_i,
  input  logic  req_i,
  input  addr_t offset_i,
  output data_t rdata_o
);

  localparam int unsigned IdxWidth = $clog2(BootromNumWords);

  data_t                rom [BootromNumWords];
  logic  [IdxWidth-1:0] word_idx;
  data_t                rdata_q;

  // Contents, word k holds the tag and k
  for (genvar k = 0; k < BootromNumWords; k++) begin : gen_rom
    assign rom[k] = {BootromTag, 16'(k)};
  end

  // Upper offset bits are dropped so the index wraps
  assign word_idx = offset_i[ByteOffset +: IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rom[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule : bootrom

// File: rtl/l2_mem.sv
// Word-interleaved L2 memory
// Consecutive words go to consecutive banks, read data returns a cycle later

module l2_mem
  import mempool_pkg::*;
#(
  parameter int unsigned NumL2Banks     = 4,
  parameter int unsigned L2BankNumWords = 256
) (
  input  logic  clk_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t offset_i,
  input  data_t wdata_i,
  input  strb_t strb_i,
  output data_t rdata_o
);

  localparam int unsigned BankBits     = $clog2(NumL2Banks);
  localparam int unsigned BankIdxWidth = (BankBits > 0) ? BankBits : 1;
  localparam int unsigned RowWidth     = $clog2(L2BankNumWords);

  logic [BankIdxWidth-1:0] bank_idx;
  logic [BankIdxWidth-1:0] bank_idx_q;
  logic [RowWidth-1:0]     row;
  logic [NumL2Banks-1:0]   bank_req;
  data_t                   bank_rdata [NumL2Banks];

  // Low word index bits pick the bank, the rest is the row
  assign bank_idx = (BankBits > 0) ? offset_i[ByteOffset +: BankIdxWidth] : '0;
  assign row      = offset_i[ByteOffset + BankBits +: RowWidth];

  for (genvar i = 0; i < NumL2Banks; i++) begin : gen_banks
    assign bank_req[i] = req_i && (bank_idx == BankIdxWidth'(i));

    l2_bank #(
      .NumWords(L2BankNumWords)
    ) l2_bank_inst (
      .clk_i  (clk_i        ),
      .req_i  (bank_req[i]  ),
      .we_i   (we_i         ),
      .row_i  (row          ),
      .wdata_i(wdata_i      ),
      .strb_i (strb_i       ),
      .rdata_o(bank_rdata[i])
    );
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      bank_idx_q <= bank_idx;
    end
  end

  assign rdata_o = bank_rdata[bank_idx_q];

endmodule : l2_mem

// File: rtl/l2_bank.sv
// Single L2 SRAM bank
// One port, byte-enable writes, read data registered on the next cycle

module l2_bank
  import mempool_pkg::*;
#(
  parameter int unsigned NumWords = 256
) (
  input  logic                        clk_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] row_i,
  input  data_t                       wdata_i,
  input  strb_t                       strb_i,
  output data_t                       rdata_o
);

  data_t mem_q [NumWords];
  data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only the enabled byte lanes change
        for (int b = 0; b < StrbWidth; b++) begin
          if (strb_i[b]) begin
            mem_q[row_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[row_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule : l2_bank

// File: rtl/mempool_addr_map_pkg.sv
// MemPool system address map
// Target windows, control register offsets and boot ROM contents tag

package mempool_addr_map_pkg;

  import mempool_pkg::*;

  // L2 window start, its size comes from the bank configuration
  localparam addr_t L2MemoryBaseAddr = 32'h8000_0000;

  // Boot ROM window
  localparam addr_t       BootromBaseAddr = 32'hA000_0000;
  localparam int unsigned BootromNumWords = 64;

  // Control register window
  localparam addr_t CtrlBaseAddr = 32'h4000_0000;
  localparam addr_t CtrlSize     = 32'h0001_0000;

  // Control register byte offsets
  localparam addr_t EocOffset      = 32'h0000_0000;
  localparam addr_t WakeUpOffset   = 32'h0000_0004;
  localparam addr_t NumCoresOffset = 32'h0000_0008;
  localparam addr_t ScratchOffset  = 32'h0000_000C;

  // Upper half of every boot ROM word
  localparam logic [15:0] BootromTag = 16'hB007;

  // Decoded destination of a host request
  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

endpackage : mempool_addr_map_pkg

// File: rtl/mempool_pkg.sv
// MemPool datapath package
// Bus widths and the vector types carried by every request and response

package mempool_pkg;

  // Byte address of the host bus
  localparam int unsigned AddrWidth = 32;

  // Word carried by a single request
  localparam int unsigned DataWidth = 32;

  // One enable per byte lane
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Address bits that select a byte inside a word
  localparam int unsigned ByteOffset = $clog2(StrbWidth);

  // Full byte address
  typedef logic [AddrWidth-1:0] addr_t;

  // One data word
  typedef logic [DataWidth-1:0] data_t;

  // Byte enables of one word
  typedef logic [StrbWidth-1:0] strb_t;

endpackage : mempool_pkg
